/* src/fpu_defs.svh */
// fpu extension constants: major opcodes, funct7 groups, register count, bus width
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// major opcodes claimed by the unit
`define FPU_OPCODE_OPFP  7'b1010011   // OP-FP arithmetic
`define FPU_OPCODE_LD    7'b0000111   // LOAD-FP, FLW
`define FPU_OPCODE_ST    7'b0100111   // STORE-FP, FSW

// funct7 of the kept OP-FP groups, fmt bits = 00 (single)
`define FPU_F7_SGNJ      7'b0010000   // fsgnj / fsgnjn / fsgnjx
`define FPU_F7_MINMAX    7'b0010100   // fmin / fmax

// width field of a word access
`define FPU_WIDTH_W      3'b010

// register file depth
`define FPU_NREGS        32

// wishbone address width
`define FPU_AW           32

// canonical quiet nan for fmin/fmax on two nans
`define FPU_CANON_NAN    32'h7fc00000

`endif

/* src/fpu_pkg.sv */
// fpu extension types: instruction layout, operation codes, decode-to-execute record
package fpu_pkg;

  // raw instruction word split by field, msb first
  // r-type and i/s-type share this layout, offsets spread over several fields
  typedef struct packed {
    logic [4:0] funct5;     // [31:27]
    logic [1:0] fmt;        // [26:25], 00 = single
    logic [4:0] rs2;        // [24:20], also imm[4:0] of a load
    logic [4:0] rs1;        // [19:15]
    logic [2:0] width_rm;   // [14:12], width on ld/st, rm on op-fp
    logic [4:0] rd;         // [11:7], also imm[4:0] of a store
    logic [6:0] opcode;     // [6:0]
  } fpu_insn_t;

  // operations the execute stage knows
  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4,
    OP_LOAD  = 3'd5,
    OP_STORE = 3'd6,
    OP_NONE  = 3'd7   // not claimed
  } fpu_op_e;

  // decode -> execute record
  typedef struct packed {
    logic        start;   // claimed word
    fpu_op_e     op;
    logic [4:0]  rs1;     // fp source a
    logic [4:0]  rs2;     // fp source b, store data
    logic [4:0]  rd;      // fp destination
    logic [11:0] imm;     // raw ld/st offset, sign-extended later
    logic [2:0]  frm;     // rounding mode, none of the kept ops round
  } decode_execute_t;

endpackage

/* src/fpu_decode.sv */
// fpu decode: claims supported fp instructions, drives register selects, builds execute record
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_decode (
  input  fpu_pkg::fpu_insn_t       insn,
  input  logic [31:0]              int_rs1,    // base register value from the core
  output logic                     insn_claim,
  output logic [4:0]               rsel_s_0,
  output logic [4:0]               rsel_s_1,
  output logic [4:0]               rsel_d,
  output fpu_pkg::decode_execute_t idex,
  output logic [31:0]              mem_addr
);

  logic [6:0]       funct7;
  logic [11:0]      imm;
  logic             is_opfp;
  logic             is_ld;
  logic             is_st;
  logic             width_ok;
  fpu_pkg::fpu_op_e op;

  assign funct7   = {insn.funct5, insn.fmt};
  assign is_opfp  = (insn.opcode == `FPU_OPCODE_OPFP);
  assign is_ld    = (insn.opcode == `FPU_OPCODE_LD);
  assign is_st    = (insn.opcode == `FPU_OPCODE_ST);
  assign width_ok = (insn.width_rm == `FPU_WIDTH_W);   // only flw / fsw

  // i-type vs s-type offset
  assign imm = is_st ? {insn.funct5, insn.fmt, insn.rd} : {insn.funct5, insn.fmt, insn.rs2};

  // core reads int rs1 from rsel_s_0, fp regs use the same fields
  assign rsel_s_0 = insn.rs1;
  assign rsel_s_1 = insn.rs2;
  assign rsel_d   = is_st ? 5'd0 : insn.rd;   // rd bits are offset on a store

  assign mem_addr = int_rs1 + {{20{imm[11]}}, imm};

  always_comb begin
    // op select
    op = fpu_pkg::OP_NONE;
    if (is_ld && width_ok) begin
      op = fpu_pkg::OP_LOAD;
    end else if (is_st && width_ok) begin
      op = fpu_pkg::OP_STORE;
    end else if (is_opfp && funct7 == `FPU_F7_SGNJ) begin
      case (insn.width_rm)
        3'd0:    op = fpu_pkg::OP_SGNJ;
        3'd1:    op = fpu_pkg::OP_SGNJN;
        3'd2:    op = fpu_pkg::OP_SGNJX;
        default: op = fpu_pkg::OP_NONE;   // reserved rm
      endcase
    end else if (is_opfp && funct7 == `FPU_F7_MINMAX) begin
      case (insn.width_rm)
        3'd0:    op = fpu_pkg::OP_MIN;
        3'd1:    op = fpu_pkg::OP_MAX;
        default: op = fpu_pkg::OP_NONE;
      endcase
    end

    // claim from the supported set, kept apart from the op table
    insn_claim = ((is_ld || is_st) && width_ok) ||
                 (is_opfp && funct7 == `FPU_F7_SGNJ   && insn.width_rm < 3'd3) ||
                 (is_opfp && funct7 == `FPU_F7_MINMAX && insn.width_rm < 3'd2);

    idex.start = insn_claim;
    idex.op    = op;
    idex.rs1   = insn.rs1;
    idex.rs2   = (is_opfp || is_st) ? insn.rs2 : 5'd0;   // load has offset here
    idex.rd    = is_st ? 5'd0 : insn.rd;
    idex.imm   = imm;
    idex.frm   = is_opfp ? insn.width_rm : 3'd0;   // passed along, unused downstream

    // claim table and op table must agree
    a_claim_has_op: assert (!insn_claim || op != fpu_pkg::OP_NONE)
      else $error("claimed word decoded to OP_NONE");
  end

endmodule

/* src/fpu_regfile.sv */
// fpu register file: 32 x 32-bit, two combinational read ports, one write port
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_regfile (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic [4:0]  raddr_a,
  input  logic [4:0]  raddr_b,
  input  logic [4:0]  waddr,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rdata_a,
  output logic [31:0] rdata_b
);

  logic [31:0] regs [`FPU_NREGS];   // f0 is a normal register

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `FPU_NREGS; i++) begin
        regs[i] <= '0;   // all regs read as +0 after reset
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // no bypass, a write lands at the edge and is visible next cycle
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

  // write address comes from execute's stage or pending load
  a_waddr_known: assert property (
    @(posedge CLK) disable iff (!rst_n) we |-> !$isunknown(waddr)
  ) else $error("regfile write with unknown address");

endmodule

/* src/fpu_execute.sv */
// fpu execute: stage register, sign injection and min/max, write-back, load/store sequencing
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_execute (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     accept,      // word taken this edge
  input  fpu_pkg::decode_execute_t idex,
  input  logic [31:0]              mem_addr,
  input  logic [31:0]              rdata_a,
  input  logic [31:0]              rdata_b,
  input  logic [31:0]              bus_rdata,
  input  logic                     bus_ack,
  output logic [4:0]               raddr_a,
  output logic [4:0]               raddr_b,
  output logic                     we,
  output logic [4:0]               waddr,
  output logic [31:0]              wdata,
  output logic                     bus_req,
  output logic                     bus_we,
  output logic [`FPU_AW-1:0]       bus_addr,
  output logic [31:0]              bus_wdata,
  output logic                     busy,
  output logic                     done
);

  logic                st_vld;    // stage holds a fresh word
  fpu_pkg::fpu_op_e    st_op;
  logic [4:0]          st_rd;
  logic [`FPU_AW-1:0]  st_addr;
  logic                st_mem;
  logic                arith;
  logic                pend;      // bus access outstanding
  logic                ld_wr;
  logic                nan_a;
  logic                nan_b;
  logic                a_lt_b;
  logic [31:0]         result;

  // control flops
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      st_vld <= 1'b0;
      pend   <= 1'b0;
      done   <= 1'b0;
    end else begin
      st_vld <= accept & idex.start;
      if (bus_req) begin
        pend <= 1'b1;
      end else if (bus_ack) begin
        pend <= 1'b0;   // ack edge closes the access
      end
      done <= arith | (pend & bus_ack);   // one cycle after write / ack
    end
  end

  // payload, held while busy since nothing else is accepted
  always_ff @(posedge CLK) begin
    if (accept) begin
      st_op   <= idex.op;
      st_rd   <= idex.rd;
      raddr_a <= idex.rs1;
      raddr_b <= idex.rs2;
      st_addr <= mem_addr[`FPU_AW-1:0];
    end
  end

  assign st_mem = (st_op == fpu_pkg::OP_LOAD) || (st_op == fpu_pkg::OP_STORE);
  assign arith  = st_vld & ~st_mem;

  // nan: exp all ones, mantissa nonzero
  assign nan_a = (rdata_a[30:23] == 8'hff) && (rdata_a[22:0] != 23'd0);
  assign nan_b = (rdata_b[30:23] == 8'hff) && (rdata_b[22:0] != 23'd0);

  // sign-magnitude order, -0 below +0
  assign a_lt_b = (rdata_a[31] != rdata_b[31]) ? rdata_a[31] :
                  rdata_a[31] ? (rdata_a[30:0] > rdata_b[30:0])
                              : (rdata_a[30:0] < rdata_b[30:0]);

  always_comb begin
    result = rdata_a;
    case (st_op)
      fpu_pkg::OP_SGNJ:  result = {rdata_b[31], rdata_a[30:0]};
      fpu_pkg::OP_SGNJN: result = {~rdata_b[31], rdata_a[30:0]};
      fpu_pkg::OP_SGNJX: result = {rdata_a[31] ^ rdata_b[31], rdata_a[30:0]};
      fpu_pkg::OP_MIN, fpu_pkg::OP_MAX: begin
        if (nan_a && nan_b) begin
          result = `FPU_CANON_NAN;
        end else if (nan_a) begin
          result = rdata_b;            // one nan -> the other operand
        end else if (nan_b) begin
          result = rdata_a;
        end else if ((st_op == fpu_pkg::OP_MIN) == a_lt_b) begin
          result = rdata_a;
        end else begin
          result = rdata_b;
        end
      end
      default: result = rdata_a;     // ld/st, result unused
    endcase
  end

  // write-back, load data lands on the ack edge
  assign ld_wr = pend & bus_ack & (st_op == fpu_pkg::OP_LOAD);
  assign we    = arith | ld_wr;
  assign waddr = st_rd;
  assign wdata = ld_wr ? bus_rdata : result;

  // bus request, one cycle after accept
  assign bus_req   = st_vld & st_mem;
  assign bus_we    = (st_op == fpu_pkg::OP_STORE);
  assign bus_addr  = st_addr;
  assign bus_wdata = rdata_b;   // store data from rs2
  assign busy      = bus_req | pend;

  a_no_accept_busy: assert property (
    @(posedge CLK) disable iff (!rst_n) !(accept && busy)
  ) else $error("instruction accepted while busy");

  a_req_pulse: assert property (
    @(posedge CLK) disable iff (!rst_n) bus_req |=> !bus_req
  ) else $error("bus request longer than one cycle");

endmodule

/* src/fpu_wb_master.sv */
// wishbone classic master doing one word read or write per request and holding the cycle until ack
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_wb_master (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               req,         // single-cycle start
  input  logic               req_we,
  input  logic [`FPU_AW-1:0] req_addr,
  input  logic [31:0]        req_wdata,
  input  logic               ack,
  input  logic [31:0]        dat_r,
  output logic               cyc,
  output logic               stb,
  output logic               we,
  output logic [`FPU_AW-1:0] adr,
  output logic [31:0]        dat_w,
  output logic [3:0]         sel,
  output logic [31:0]        rdata,
  output logic               ack_pulse
);

  logic [31:0] rdata_q;   // last word read

  // cycle control
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
    end else if (req) begin
      cyc <= 1'b1;   // cyc and stb rise together
      stb <= 1'b1;
      we  <= req_we;
    end else if (cyc && ack) begin
      cyc <= 1'b0;   // drop on the edge after ack seen
      stb <= 1'b0;
      we  <= 1'b0;
    end
  end

  // address and data latch
  always_ff @(posedge CLK) begin
    if (req) begin
      adr   <= req_addr;
      dat_w <= req_wdata;
    end
    if (cyc && ack && !we) begin
      rdata_q <= dat_r;
    end
  end

  assign sel       = 4'hf;   // word access only
  assign ack_pulse = cyc & ack;
  // read data valid during the ack cycle and held after
  assign rdata     = ack_pulse ? dat_r : rdata_q;

  a_stb_in_cyc: assert property (
    @(posedge CLK) disable iff (!rst_n) stb |-> cyc
  ) else $error("stb without cyc");

  // execute must not issue while a cycle is open
  a_req_idle: assert property (
    @(posedge CLK) disable iff (!rst_n) req |-> !cyc
  ) else $error("request during open bus cycle");

endmodule

/* src/fpu_ext.sv */
// fpu extension top: decode, execute, register file and wishbone master for the core
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_ext (
  input  logic               CLK,
  input  logic               rst_n,
  // core side
  input  logic               insn_valid,
  input  logic [31:0]        insn,
  input  logic [31:0]        int_rs1,     // core's value of rsel_s_0
  output logic               insn_claim,
  output logic [4:0]         rsel_s_0,
  output logic [4:0]         rsel_s_1,
  output logic [4:0]         rsel_d,
  output logic               busy,
  output logic               done,
  // wishbone
  output logic               cyc,
  output logic               stb,
  output logic               we,
  output logic [`FPU_AW-1:0] adr,
  output logic [31:0]        dat_w,
  output logic [3:0]         sel,
  input  logic [31:0]        dat_r,
  input  logic               ack
);

  fpu_pkg::decode_execute_t idex;
  logic [31:0]              mem_addr;
  logic                     accept;
  logic [4:0]               rf_raddr_a;
  logic [4:0]               rf_raddr_b;
  logic [4:0]               rf_waddr;
  logic                     rf_we;
  logic [31:0]              rf_wdata;
  logic [31:0]              rf_rdata_a;
  logic [31:0]              rf_rdata_b;
  logic                     bus_req;
  logic                     bus_we;
  logic [`FPU_AW-1:0]       bus_addr;
  logic [31:0]              bus_wdata;
  logic [31:0]              bus_rdata;
  logic                     bus_ack;

  // handshake, core holds the word while busy
  assign accept = insn_valid & insn_claim & ~busy;

  fpu_decode u_decode (
    .insn       (fpu_pkg::fpu_insn_t'(insn)),
    .int_rs1    (int_rs1),
    .insn_claim (insn_claim),
    .rsel_s_0   (rsel_s_0),
    .rsel_s_1   (rsel_s_1),
    .rsel_d     (rsel_d),
    .idex       (idex),
    .mem_addr   (mem_addr)
  );

  fpu_regfile u_regfile (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .raddr_a (rf_raddr_a),
    .raddr_b (rf_raddr_b),
    .waddr   (rf_waddr),
    .we      (rf_we),
    .wdata   (rf_wdata),
    .rdata_a (rf_rdata_a),
    .rdata_b (rf_rdata_b)
  );

  fpu_execute u_execute (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .accept    (accept),
    .idex      (idex),
    .mem_addr  (mem_addr),
    .rdata_a   (rf_rdata_a),
    .rdata_b   (rf_rdata_b),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .raddr_a   (rf_raddr_a),
    .raddr_b   (rf_raddr_b),
    .we        (rf_we),
    .waddr     (rf_waddr),
    .wdata     (rf_wdata),
    .bus_req   (bus_req),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .busy      (busy),
    .done      (done)
  );

  fpu_wb_master u_wb_master (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .req       (bus_req),
    .req_we    (bus_we),
    .req_addr  (bus_addr),
    .req_wdata (bus_wdata),
    .ack       (ack),
    .dat_r     (dat_r),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .sel       (sel),
    .rdata     (bus_rdata),
    .ack_pulse (bus_ack)
  );

endmodule

/* tests/tb_clock_gen.sv */
// testbench clock source, free running square wave
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter real PERIOD = 8.0   // ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2.0) clk = ~clk;   // half period per phase

endmodule

/* tests/tb_fpu_ext.sv */
// fpu extension testbench with core stimulus, wishbone memory, reference model and checks
`timescale 1ns/10ps
`include "fpu_defs.svh"

module tb_fpu_ext;

  // instruction count per test in order reset, round trip, sgnj, minmax, filter, back-pressure
  localparam int N_INSN = 3 + 12 + 8 + 48 + 5 + 8;

  logic        CLK;
  logic        rst_n;
  logic        insn_valid;
  logic [31:0] insn;
  logic [31:0] int_rs1;
  logic        insn_claim;
  logic [4:0]  rsel_s_0;
  logic [4:0]  rsel_s_1;
  logic [4:0]  rsel_d;
  logic        busy;
  logic        done;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [31:0] adr;
  logic [31:0] dat_w;
  logic [3:0]  sel;
  logic [31:0] dat_r;
  logic        ack;
  logic        acc_arith;                 // arithmetic word taken this edge
  logic [31:0] mem [256];                 // wishbone memory, word indexed
  logic [31:0] model [32];                // expected fp register contents
  logic [31:0] exp_adr;                   // address of the access in flight
  logic [31:0] exp_dat;                   // store data of the access in flight
  logic        exp_we;                    // direction of the access in flight
  int          wait_cnt = 0;
  int          bus_cnt = 0;
  int          done_cnt = 0;
  int          errors = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;

  tb_clock_gen #(.PERIOD(8.0)) u_clock_gen (.clk(CLK));

  fpu_ext u_fpu_ext (
    .CLK(CLK), .rst_n(rst_n), .insn_valid(insn_valid), .insn(insn), .int_rs1(int_rs1),
    .insn_claim(insn_claim), .rsel_s_0(rsel_s_0), .rsel_s_1(rsel_s_1), .rsel_d(rsel_d),
    .busy(busy), .done(done), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
    .sel(sel), .dat_r(dat_r), .ack(ack)
  );

  function automatic logic [31:0] enc_flw(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    fpu_pkg::fpu_insn_t i;
    i = '{imm[11:7], imm[6:5], imm[4:0], rs1, `FPU_WIDTH_W, rd, `FPU_OPCODE_LD};
    return i;
  endfunction

  function automatic logic [31:0] enc_fsw(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    fpu_pkg::fpu_insn_t i;
    i = '{imm[11:7], imm[6:5], rs2, rs1, `FPU_WIDTH_W, imm[4:0], `FPU_OPCODE_ST};
    return i;
  endfunction

  function automatic logic [31:0] enc_opfp(input logic [6:0] f7, input logic [2:0] rm,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    fpu_pkg::fpu_insn_t i;
    i = '{f7[6:2], f7[1:0], rs2, rs1, rm, rd, `FPU_OPCODE_OPFP};
    return i;
  endfunction

  // supported set is flw/fsw words, sgnj rm 0..2 and min/max rm 0..1
  function automatic logic claim_ref(input logic [31:0] w);
    if (w[6:0] == `FPU_OPCODE_LD || w[6:0] == `FPU_OPCODE_ST) return w[14:12] == 3'b010;
    if (w[6:0] != `FPU_OPCODE_OPFP) return 1'b0;
    if (w[31:25] == `FPU_F7_SGNJ) return w[14:12] inside {3'd0, 3'd1, 3'd2};
    if (w[31:25] == `FPU_F7_MINMAX) return w[14:12] inside {3'd0, 3'd1};
    return 1'b0;
  endfunction

  // maps a float to an unsigned key with the same order and -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
  endfunction

  function automatic logic nan_check(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 0);
  endfunction

  function automatic logic [31:0] minmax_ref(input logic [31:0] a, input logic [31:0] b,
                                             input logic is_max);
    if (nan_check(a) && nan_check(b)) return `FPU_CANON_NAN;
    if (nan_check(a)) return b;
    if (nan_check(b)) return a;
    if (is_max) return (order_key(a) >= order_key(b)) ? a : b;
    return (order_key(a) <= order_key(b)) ? a : b;
  endfunction

  assign acc_arith = insn_valid && insn_claim && !busy && insn[6:0] == `FPU_OPCODE_OPFP;

  // wishbone memory with random 0..3 wait cycles before ack
  always @(posedge CLK) begin
    if (cyc && stb && ack) begin
      if (we) mem[adr[9:2]] = dat_w;   // write lands on the ack edge
      bus_cnt++;
      wait_cnt = $urandom_range(0, 3);
      #1 ack = 1'b0;
    end else if (cyc && stb) begin
      if (wait_cnt == 0) begin
        #1;
        dat_r = mem[adr[9:2]];
        ack   = 1'b1;
      end else begin
        wait_cnt--;
      end
    end
  end

  always @(posedge CLK) begin
    if (done) done_cnt++;
  end

  a_claim: assert property (@(posedge CLK) disable iff (!rst_n)
    insn_valid |-> insn_claim == claim_ref(insn))
    else begin
      $display("mismatch at %0t: claim %b for word %h", $time, insn_claim, insn);
      errors++;
    end

  // register selects follow the instruction fields, rd is an offset on a store
  a_rsel: assert property (@(posedge CLK) disable iff (!rst_n)
    insn_valid |-> (rsel_s_0 == insn[19:15] && rsel_s_1 == insn[24:20] &&
                    (insn[6:0] == `FPU_OPCODE_ST || rsel_d == insn[11:7])))
    else begin
      $display("mismatch at %0t: register selects %0d %0d %0d for word %h", $time,
               rsel_s_0, rsel_s_1, rsel_d, insn);
      errors++;
    end

  a_bus_adr: assert property (@(posedge CLK) disable iff (!rst_n)
    (cyc && stb && ack) |-> adr == exp_adr)
    else begin
      $display("mismatch at %0t: bus address %h, expected %h", $time, adr, exp_adr);
      errors++;
    end

  a_bus_ctl: assert property (@(posedge CLK) disable iff (!rst_n)
    (cyc && stb && ack) |-> (we == exp_we && sel == 4'hf))
    else begin
      $display("mismatch at %0t: bus we %b sel %h, expected we %b sel f", $time,
               we, sel, exp_we);
      errors++;
    end

  a_store_dat: assert property (@(posedge CLK) disable iff (!rst_n)
    (cyc && stb && ack && we) |-> dat_w == exp_dat)
    else begin
      $display("mismatch at %0t: store data %h, expected %h", $time, dat_w, exp_dat);
      errors++;
    end

  a_done_arith: assert property (@(posedge CLK) disable iff (!rst_n)
    $past(acc_arith, 2) |-> done)
    else begin
      $display("mismatch at %0t: done missing after arithmetic accept", $time);
      errors++;
    end

  a_done_cause: assert property (@(posedge CLK) disable iff (!rst_n)
    done |-> ($past(acc_arith, 2) || $past(cyc && ack)))
    else begin
      $display("mismatch at %0t: done without a retiring instruction", $time);
      errors++;
    end

  a_hold_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
    (cyc && !ack) |=> (cyc && stb && busy))
    else begin
      $display("bus cycle or busy dropped before ack at %0t", $time);
      errors++;
    end

  a_reset_idle: assert property (@(posedge CLK)
    !rst_n |-> (!cyc && !stb && !busy && !done))
    else begin
      $display("bus or handshake outputs active during reset at %0t", $time);
      errors++;
    end

  // present a word from edge+1ns and return on the edge that takes it
  task automatic issue_insn(input logic [31:0] w, input logic [31:0] base);
    insn       = w;
    int_rs1    = base;
    insn_valid = 1'b1;
    forever begin
      @(posedge CLK);
      if (!busy) break;   // held by the core while busy
    end
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] base,
                          input logic [11:0] imm);
    logic [31:0] a;
    a = base + {{20{imm[11]}}, imm};
    issue_insn(enc_flw(rd, 5'($urandom), imm), base);
    exp_adr   = a;
    exp_we    = 1'b0;
    model[rd] = mem[a[9:2]];
    #1;
  endtask

  task automatic store_reg(input logic [4:0] rs2, input logic [31:0] base,
                           input logic [11:0] imm);
    issue_insn(enc_fsw(rs2, 5'($urandom), imm), base);
    exp_adr = base + {{20{imm[11]}}, imm};
    exp_we  = 1'b1;
    exp_dat = model[rs2];
    #1;
  endtask

  task automatic fp_op(input logic [6:0] f7, input logic [2:0] rm, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] a;
    logic [31:0] b;
    a = model[rs1];
    b = model[rs2];
    issue_insn(enc_opfp(f7, rm, rd, rs1, rs2), 32'd0);
    if (f7 == `FPU_F7_MINMAX) model[rd] = minmax_ref(a, b, rm[0]);
    else if (rm == 3'd0) model[rd] = (a & 32'h7fff_ffff) | (b & 32'h8000_0000);
    else if (rm == 3'd1) model[rd] = (a & 32'h7fff_ffff) | (~b & 32'h8000_0000);
    else model[rd] = a ^ (b & 32'h8000_0000);
    #1;
  endtask

  task automatic settle_bus();
    insn_valid = 1'b0;
    while (busy || cyc) @(posedge CLK);
    repeat (3) @(posedge CLK);
    #1;
  endtask

  task automatic present_unclaimed(input logic [31:0] w);
    insn       = w;
    insn_valid = 1'b1;
    repeat (3) @(posedge CLK);
    #1 insn_valid = 1'b0;
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) tests_pass++;
    else tests_fail++;
    $display("%-16s %s (%0d errors)", name, (errors == err0) ? "pass" : "fail", errors - err0);
  endtask

  initial begin
    logic [31:0] ops_a [8];
    logic [31:0] ops_b [8];
    logic [31:0] bad [5];
    int          err0;
    int          bus0;
    int          done0;
    void'($urandom(34));
    insn_valid = 1'b0;
    insn       = '0;
    int_rs1    = '0;
    dat_r      = '0;
    ack        = 1'b0;
    rst_n      = 1'b0;
    exp_adr    = '0;
    exp_dat    = '0;
    exp_we     = 1'b0;
    for (int i = 0; i < 256; i++) mem[i] = $urandom;
    for (int i = 0; i < 32; i++) model[i] = '0;   // regs cleared by reset
    ops_a = '{32'h0, 32'h8000_0000, 32'h7fc0_0000, 32'h3f80_0000,
              32'h7f80_0001, 32'hc000_0000, 32'hbf80_0000, 32'h7f80_0000};
    ops_b = '{32'h8000_0000, 32'h0, 32'h3f80_0000, 32'h7fc0_0000,
              32'h7fc0_0000, 32'h4060_0000, 32'hc040_0000, 32'h40a0_0000};
    bad   = '{32'h00b5_0533, 32'h00b5_7553,
              enc_opfp(`FPU_F7_SGNJ, 3'd3, 5'd1, 5'd2, 5'd3),
              enc_opfp(`FPU_F7_MINMAX, 3'd2, 5'd1, 5'd2, 5'd3), 32'h0001_3087};
    repeat (8) @(posedge CLK);
    #1 rst_n = 1'b1;

    // reset state with registers reading back as zero
    err0 = errors;
    assert (!cyc && !stb && !busy && !done)
      else begin
        $display("outputs not idle right after reset");
        errors++;
      end
    for (int i = 0; i < 3; i++) store_reg(5'($urandom), $urandom & ~32'd3, 12'(16 * i));
    settle_bus();
    report_test("reset_state", err0);

    // load into regs then store each to a fresh address
    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      load_reg(5'(i + 10), $urandom & ~32'd3, 12'($urandom_range(0, 1023) * 4));
      store_reg(5'(i + 10), $urandom & ~32'd3, 12'($urandom_range(0, 1023) * 4));
    end
    settle_bus();
    report_test("round_trip", err0);

    // sign injection back to back
    err0 = errors;
    load_reg(5'd1, 32'd0, 12'd40);
    load_reg(5'd2, 32'd0, 12'd44);
    fp_op(`FPU_F7_SGNJ, 3'd0, 5'd3, 5'd1, 5'd2);
    fp_op(`FPU_F7_SGNJ, 3'd1, 5'd4, 5'd1, 5'd2);
    fp_op(`FPU_F7_SGNJ, 3'd2, 5'd5, 5'd1, 5'd2);
    for (int r = 3; r < 6; r++) store_reg(5'(r), 32'h100, 12'(r * 4));
    settle_bus();
    report_test("sign_injection", err0);

    // min and max with zeros and nans
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      mem[250] = ops_a[i];
      mem[251] = ops_b[i];
      load_reg(5'd6, 32'd0, 12'd1000);
      load_reg(5'd7, 32'd0, 12'd1004);
      fp_op(`FPU_F7_MINMAX, 3'd0, 5'd8, 5'd6, 5'd7);
      fp_op(`FPU_F7_MINMAX, 3'd1, 5'd9, 5'd6, 5'd7);
      store_reg(5'd8, 32'h200, 12'd0);
      store_reg(5'd9, 32'h200, 12'd4);
      settle_bus();
    end
    report_test("min_max", err0);

    // unsupported words raise no bus cycle and no done
    err0  = errors;
    bus0  = bus_cnt;
    done0 = done_cnt;
    foreach (bad[i]) present_unclaimed(bad[i]);
    settle_bus();
    assert (bus_cnt == bus0 && done_cnt == done0)
      else begin
        $display("unclaimed word started a bus cycle or raised done");
        errors++;
      end
    report_test("claim_filter", err0);

    // loads and stores held while busy and each taken once
    err0  = errors;
    bus0  = bus_cnt;
    done0 = done_cnt;
    for (int i = 0; i < 4; i++) begin
      load_reg(5'(20 + i), $urandom & ~32'd3, 12'hff0);
      store_reg(5'(20 + i), $urandom & ~32'd3, 12'h010);
    end
    settle_bus();
    assert (bus_cnt - bus0 == 8 && done_cnt - done0 == 8)
      else begin
        $display("held instructions were not taken exactly once");
        errors++;
      end
    report_test("back_pressure", err0);

    $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
    if (errors == 0 && tests_fail == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog sized from the instruction count
  initial begin
    repeat (N_INSN * 200 + 1000) @(posedge CLK);
    $display("watchdog expired, run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+src
src/fpu_pkg.sv
src/fpu_decode.sv
src/fpu_regfile.sv
src/fpu_execute.sv
src/fpu_wb_master.sv
src/fpu_ext.sv
tests/tb_clock_gen.sv
tests/tb_fpu_ext.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fpu extension testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_fpu_ext -o sim_fpu_ext
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_fpu_ext > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
